// ==== compile.f ====
logic/chip8_isa_pkg.sv
logic/chip8_mem_pkg.sv
logic/opcode_stream_if.sv
logic/opcode_fetch.sv
logic/opcode_queue.sv
logic/chip8_execute.sv
logic/chip8_core.sv
tests/chip8_assert.sv
tests/chip8_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := chip8_tb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/chip8_tb.sv ====
/* Testbench for the CHIP-8 core: byte memory model with a fixed and a random
   program; the bound checker does the checking, this top ends the run */
`timescale 1ns/1ps

module chip8_tb;

  localparam int          N_RANDOM  = 64;
  localparam logic [11:0] RAND_BASE = 12'h240;
  localparam logic [11:0] LOOP_PC   = 12'h2F0;
  localparam int          N_OPS     = 40 + N_RANDOM;
  localparam int          TIMEOUT   = 10 + N_OPS * 40 + 500;  // cycles

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        mem_read;
  logic [11:0] mem_addr;
  logic [7:0]  mem_data = 8'h00;
  logic        retire;
  logic [11:0] retire_pc;
  logic        wb_valid;
  logic [3:0]  wb_index;
  logic [7:0]  wb_data;

  logic [7:0]  mem [4096];
  logic        rd_pend = 1'b0;
  logic [11:0] addr_pend = '0;
  logic [11:0] load_pc;

  always #10 clk = ~clk;

  chip8_core #(
    .QUEUE_DEPTH (4),
    .STACK_DEPTH (16)
  ) dut (
    .clk       (clk),
    .reset     (reset),
    .mem_read  (mem_read),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .retire    (retire),
    .retire_pc (retire_pc),
    .wb_valid  (wb_valid),
    .wb_index  (wb_index),
    .wb_data   (wb_data)
  );

  // data for a read seen in one cycle is driven in the next
  always @(negedge clk) begin
    if (rd_pend) mem_data <= mem[addr_pend];
    rd_pend   <= mem_read;
    addr_pend <= mem_addr;
  end

  task automatic emit(input logic [15:0] op);
    mem[load_pc]         = op[15:8];  // high byte first
    mem[load_pc + 12'd1] = op[7:0];
    load_pc              = load_pc + 12'd2;
  endtask

  function automatic logic [15:0] random_op();
    logic [3:0] x;
    logic [3:0] y;
    logic [3:0] fn;
    logic [7:0] kk;
    int         kind;
    int         fn_sel;
    x      = 4'($urandom);
    y      = 4'($urandom);
    kk     = 8'($urandom);
    kind   = int'($urandom % 3);
    fn_sel = int'($urandom % 9);
    fn     = (fn_sel == 8) ? 4'hE : 4'(fn_sel);
    if (kind == 0) return {4'h6, x, kk};
    else if (kind == 1) return {4'h7, x, kk};
    else return {4'h8, x, y, fn};
  endfunction

  task automatic load_program();
    logic [11:0] a;
    for (int i = 0; i < 4096; i++) begin
      a      = 12'(i);
      mem[i] = a[7:0] ^ {a[11:8], a[11:8]};
    end
    load_pc = 12'h200;
    emit(16'h00E0);
    emit(16'h6005);  // V0=5
    emit(16'h61FF);
    emit(16'h7103);  // wraps to 02
    emit(16'h6205);
    emit(16'h3005);  // taken
    emit(16'h6399);
    emit(16'h3006);
    emit(16'h4006);  // taken
    emit(16'h6399);
    emit(16'h4005);
    emit(16'h5020);  // taken
    emit(16'h6399);
    emit(16'h5010);
    emit(16'h9010);  // taken
    emit(16'h6399);
    emit(16'h9020);
    emit(16'h8300);
    emit(16'h8311);
    emit(16'h8322);
    emit(16'h8313);
    emit(16'h8414);
    emit(16'h64F0);
    emit(16'h65FF);
    emit(16'h8454);  // carry out
    emit(16'h8405);
    emit(16'h8516);
    emit(16'h8507);
    emit(16'h851E);
    emit(16'h8F14);  // flag lands in VF itself
    emit(16'h2300);
    emit(16'hB23B);  // 23B + V0 = 240
    load_pc = RAND_BASE;
    for (int k = 0; k < N_RANDOM; k++) begin
      emit(random_op());
    end
    emit({4'h1, LOOP_PC});
    load_pc = LOOP_PC;
    emit({4'h1, LOOP_PC});
    load_pc = 12'h300;
    emit(16'h6642);
    emit(16'h00EE);
  endtask

  always @(negedge clk) begin
    if (dut.chk.fail) begin
      $display("Finished with errors");
      $fatal(1, "checker assertion failed");
    end
  end

  initial begin
    repeat (TIMEOUT) @(posedge clk);
    $display("Timeout: the program did not reach its final loop");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'hbe7e2343));
    load_program();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    do begin
      @(negedge clk);
    end while (!(retire && retire_pc == LOOP_PC));
    if (dut.chk.fail) begin
      $display("Finished with errors");
      $fatal(1, "checker assertion failed");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== tests/chip8_assert.sv ====
/* Checker bound into the core: keeps a shadow CHIP-8 model advanced on each retire
   and checks retire order, write-backs, reset state and memory read order */
`timescale 1ns/1ps

module chip8_assert
  import chip8_isa_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        mem_read,
  input logic [11:0] mem_addr,
  input logic [7:0]  mem_data,
  input logic        redirect,
  input logic        retire,
  input logic [11:0] retire_pc,
  input logic        wb_valid,
  input logic [3:0]  wb_index,
  input logic [7:0]  wb_data
);

  logic        fail = 1'b0;   // read by the testbench
  logic [7:0]  seen_mem [4096];  // bytes observed on the memory port
  logic        rd_q;
  logic [11:0] rd_addr_q;
  logic [7:0]  v [16];
  logic [11:0] stk [16];
  logic [3:0]  sp;
  logic [11:0] exp_pc;
  logic        flag_due;
  logic        flag_exp;
  logic        stretch;       // reads since last redirect
  logic        read_seen;
  logic [11:0] last_addr;

  logic [15:0] op;
  logic [3:0]  c;
  logic [3:0]  x;
  logic [3:0]  y;
  logic [3:0]  n;
  logic [7:0]  kk;
  logic [7:0]  vx;
  logic [7:0]  vy;
  logic [8:0]  wide;
  logic [11:0] next_pc;
  logic        wr;
  logic [7:0]  res;
  logic        flag_op;
  logic        flag;

  always_comb begin
    op      = {seen_mem[retire_pc], seen_mem[retire_pc + 12'd1]};
    c       = op[15:12];
    x       = op[11:8];
    y       = op[7:4];
    n       = op[3:0];
    kk      = op[7:0];
    vx      = v[x];
    vy      = v[y];
    wide    = {1'b0, vx} + {1'b0, vy};
    next_pc = retire_pc + 12'd2;
    wr      = 1'b0;
    res     = 8'h00;
    flag_op = 1'b0;
    flag    = 1'b0;
    case (c)
      4'h0: if (op == 16'h00EE) next_pc = stk[sp - 4'd1];
      4'h1: next_pc = op[11:0];
      4'h2: next_pc = op[11:0];
      4'h3: if (vx == kk) next_pc = retire_pc + 12'd4;
      4'h4: if (vx != kk) next_pc = retire_pc + 12'd4;
      4'h5: if (n == 4'h0 && vx == vy) next_pc = retire_pc + 12'd4;
      4'h9: if (n == 4'h0 && vx != vy) next_pc = retire_pc + 12'd4;
      4'h6: begin
        wr  = 1'b1;
        res = kk;
      end
      4'h7: begin
        wr  = 1'b1;
        res = vx + kk;  // mod 256
      end
      4'h8: begin
        wr = 1'b1;
        case (n)
          4'h0: res = vy;
          4'h1: res = vx | vy;
          4'h2: res = vx & vy;
          4'h3: res = vx ^ vy;
          4'h4: begin
            res     = wide[7:0];
            flag    = wide[8];
            flag_op = 1'b1;
          end
          4'h5: begin
            res     = vx - vy;
            flag    = vx >= vy;  // no borrow
            flag_op = 1'b1;
          end
          4'h6: begin
            res     = vx >> 1;
            flag    = vx[0];
            flag_op = 1'b1;
          end
          4'h7: begin
            res     = vy - vx;
            flag    = vy >= vx;
            flag_op = 1'b1;
          end
          4'hE: begin
            res     = vx << 1;
            flag    = vx[7];
            flag_op = 1'b1;
          end
          default: wr = 1'b0;
        endcase
      end
      4'hB: next_pc = op[11:0] + {4'h0, v[0]};
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_q) begin
      seen_mem[rd_addr_q] <= mem_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_q      <= 1'b0;
      rd_addr_q <= '0;
      sp        <= '0;
      exp_pc    <= START_PC;
      flag_due  <= 1'b0;
      flag_exp  <= 1'b0;
      stretch   <= 1'b0;
      read_seen <= 1'b0;
      last_addr <= '0;
      for (int i = 0; i < 16; i++) begin
        v[i] <= '0;
      end
    end else begin
      rd_q      <= mem_read;
      rd_addr_q <= mem_addr;
      if (mem_read) begin
        last_addr <= mem_addr;
        read_seen <= 1'b1;
      end
      stretch  <= redirect ? 1'b0 : (mem_read | stretch);
      flag_due <= retire & flag_op;
      flag_exp <= flag;
      if (retire) begin
        exp_pc <= next_pc;
        if (wr) v[x] <= res;
        if (flag_op) v[15] <= {7'd0, flag};  // VF after the result
        if (c == 4'h2) begin
          stk[sp] <= retire_pc + 12'd2;
          sp      <= sp + 4'd1;
        end else if (op == 16'h00EE) begin
          sp <= sp - 4'd1;
        end
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    reset |-> !mem_read && !retire && !wb_valid)
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: outputs active during reset", $time);
  end

  a_after_reset: assert property (@(posedge clk)
    $fell(reset) |=> !retire && !wb_valid)
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: outputs active on the first cycle after reset", $time);
  end

  a_first_addr: assert property (@(posedge clk) disable iff (reset)
    mem_read && !read_seen |-> mem_addr == START_PC)
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: first read expected %h got %h", $time, START_PC, mem_addr);
  end

  a_retire_pc: assert property (@(posedge clk) disable iff (reset)
    retire |-> retire_pc == exp_pc)
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: retire_pc expected %h got %h", $time, exp_pc, retire_pc);
  end

  a_wb_result: assert property (@(posedge clk) disable iff (reset)
    retire && wr |-> wb_valid && wb_index == x && wb_data == res)
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: write-back expected V%h=%h got valid %b V%h=%h",
           $time, x, res, wb_valid, wb_index, wb_data);
  end

  a_wb_flag: assert property (@(posedge clk) disable iff (reset)
    flag_due |-> wb_valid && wb_index == FLAG_REG && wb_data == {7'd0, flag_exp})
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: VF write-back expected %h got valid %b V%h=%h",
           $time, flag_exp, wb_valid, wb_index, wb_data);
  end

  a_wb_quiet: assert property (@(posedge clk) disable iff (reset)
    !(retire && wr) && !flag_due |-> !wb_valid)
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: write-back expected none got V%h=%h", $time, wb_index, wb_data);
  end

  a_read_step: assert property (@(posedge clk) disable iff (reset)
    mem_read && stretch |-> mem_addr == last_addr + 12'd1)
  else begin
    fail = 1'b1;
    $error("Mismatch at %0t: read address expected %h got %h",
           $time, last_addr + 12'd1, mem_addr);
  end

endmodule

bind chip8_core chip8_assert chk (
  .clk       (clk),
  .reset     (reset),
  .mem_read  (mem_read),
  .mem_addr  (mem_addr),
  .mem_data  (mem_data),
  .redirect  (redirect),
  .retire    (retire),
  .retire_pc (retire_pc),
  .wb_valid  (wb_valid),
  .wb_index  (wb_index),
  .wb_data   (wb_data)
);

// ==== logic/chip8_core.sv ====
/* CHIP-8 core top level: fetch, opcode queue and execute stage joined to the byte
   memory port and the retire and write-back trace outputs */
`timescale 1ns/1ps

module chip8_core
  import chip8_mem_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int STACK_DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  output logic                 mem_read,
  output logic [ADDR_W-1:0]    mem_addr,
  input  logic [DATA_W-1:0]    mem_data,
  output logic                 retire,
  output logic [ADDR_W-1:0]    retire_pc,
  output logic                 wb_valid,
  output logic [REG_IDX_W-1:0] wb_index,
  output logic [DATA_W-1:0]    wb_data
);

  logic              redirect;
  logic [ADDR_W-1:0] redirect_pc;

  opcode_stream_if fetch_link ();
  opcode_stream_if issue_link ();

  opcode_fetch u_fetch (
    .clk         (clk),
    .reset       (reset),
    .mem_read    (mem_read),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out         (fetch_link.source)
  );

  opcode_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk      (clk),
    .reset    (reset),
    .redirect (redirect),
    .in       (fetch_link.sink),
    .out      (issue_link.source)
  );

  chip8_execute #(
    .STACK_DEPTH (STACK_DEPTH)
  ) u_execute (
    .clk         (clk),
    .reset       (reset),
    .in          (issue_link.sink),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .retire      (retire),
    .retire_pc   (retire_pc),
    .wb_valid    (wb_valid),
    .wb_index    (wb_index),
    .wb_data     (wb_data)
  );

endmodule

// ==== logic/chip8_execute.sv ====
/* Execute stage: holds V0-VF and the return stack, runs one popped opcode per
   cycle, redirects fetch on taken control flow and reports retire and write-back */
`timescale 1ns/1ps

module chip8_execute
  import chip8_isa_pkg::*, chip8_mem_pkg::*;
#(
  parameter int STACK_DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  opcode_stream_if.sink        in,
  output logic                 redirect,
  output logic [ADDR_W-1:0]    redirect_pc,
  output logic                 retire,
  output logic [ADDR_W-1:0]    retire_pc,
  output logic                 wb_valid,
  output logic [REG_IDX_W-1:0] wb_index,
  output logic [DATA_W-1:0]    wb_data
);

  localparam int SP_W = $clog2(STACK_DEPTH);

  logic [DATA_W-1:0] v_reg [NUM_REGS];
  logic [ADDR_W-1:0] stack_mem [STACK_DEPTH];
  logic [SP_W-1:0]   sp;
  logic [SP_W-1:0]   sp_top;
  logic              flag_pend;  // VF write-back owed from the last 8xy
  logic              flag_val;

  opcode_t              op;
  logic                 pop;
  logic [DATA_W-1:0]    vx;
  logic [DATA_W-1:0]    vy;
  logic [DATA_W-1:0]    kk;
  logic [DATA_W:0]      sum_xy;
  logic [DATA_W:0]      diff_xy;
  logic [DATA_W:0]      diff_yx;
  logic [DATA_W-1:0]    alu_res;
  logic                 alu_flag;
  logic                 alu_sets_flag;
  logic                 alu_writes;
  logic [ADDR_W-1:0]    seq_pc;
  logic [ADDR_W-1:0]    skip_pc;
  logic [ADDR_W-1:0]    target;
  logic                 jump;
  logic                 push_ret;
  logic                 pop_ret;
  logic                 wr_en;
  logic                 flag_en;
  logic [DATA_W-1:0]    wr_val;
  logic                 rf_we;
  logic [REG_IDX_W-1:0] rf_idx;
  logic [DATA_W-1:0]    rf_data;

  assign op      = in.opcode;
  assign in.take = ~redirect & ~flag_pend;
  assign pop     = in.valid & in.take;

  assign vx      = v_reg[op.regs.x];
  assign vy      = v_reg[op.regs.y];
  assign kk      = {op.regs.y, op.regs.fn};
  assign sum_xy  = {1'b0, vx} + {1'b0, vy};
  assign diff_xy = {1'b0, vx} - {1'b0, vy};  // msb set on borrow
  assign diff_yx = {1'b0, vy} - {1'b0, vx};
  assign sp_top  = sp - 1'b1;
  assign seq_pc  = in.pc + INSTR_BYTES;
  assign skip_pc = seq_pc + INSTR_BYTES;

  always_comb begin
    alu_res       = vx;
    alu_flag      = 1'b0;
    alu_sets_flag = 1'b1;
    alu_writes    = 1'b1;
    case (op.regs.fn)
      ALU_MOV: begin
        alu_res       = vy;
        alu_sets_flag = 1'b0;
      end
      ALU_OR: begin
        alu_res       = vx | vy;
        alu_sets_flag = 1'b0;
      end
      ALU_AND: begin
        alu_res       = vx & vy;
        alu_sets_flag = 1'b0;
      end
      ALU_XOR: begin
        alu_res       = vx ^ vy;
        alu_sets_flag = 1'b0;
      end
      ALU_ADD: begin
        alu_res  = sum_xy[DATA_W-1:0];
        alu_flag = sum_xy[DATA_W];  // carry
      end
      ALU_SUB: begin
        alu_res  = diff_xy[DATA_W-1:0];
        alu_flag = ~diff_xy[DATA_W];  // not borrow
      end
      ALU_SHR: begin
        alu_res  = vx >> 1;
        alu_flag = vx[0];
      end
      ALU_SUBN: begin
        alu_res  = diff_yx[DATA_W-1:0];
        alu_flag = ~diff_yx[DATA_W];
      end
      ALU_SHL: begin
        alu_res  = vx << 1;
        alu_flag = vx[DATA_W-1];
      end
      default: begin
        alu_writes    = 1'b0;
        alu_sets_flag = 1'b0;
      end
    endcase
  end

  always_comb begin
    jump     = 1'b0;
    target   = seq_pc;
    push_ret = 1'b0;
    pop_ret  = 1'b0;
    wr_en    = 1'b0;
    wr_val   = alu_res;
    flag_en  = 1'b0;
    case (op.addr.cls)
      CLS_SYS: begin
        if (op == RET_OPCODE) begin
          jump    = 1'b1;
          target  = stack_mem[sp_top];
          pop_ret = 1'b1;
        end
      end
      CLS_JP: begin
        jump   = 1'b1;
        target = op.addr.target;
      end
      CLS_CALL: begin
        jump     = 1'b1;
        target   = op.addr.target;
        push_ret = 1'b1;
      end
      CLS_SE_IMM:  jump = vx == kk;
      CLS_SNE_IMM: jump = vx != kk;
      CLS_SE_REG:  jump = (op.regs.fn == 4'h0) && (vx == vy);
      CLS_SNE_REG: jump = (op.regs.fn == 4'h0) && (vx != vy);
      CLS_LD_IMM: begin
        wr_en  = 1'b1;
        wr_val = kk;
      end
      CLS_ADD_IMM: begin
        wr_en  = 1'b1;
        wr_val = vx + kk;  // wraps, VF untouched
      end
      CLS_ALU: begin
        wr_en   = alu_writes;
        flag_en = alu_sets_flag;
      end
      CLS_JP_V0: begin
        jump   = 1'b1;
        target = op.addr.target + {{(ADDR_W - DATA_W){1'b0}}, v_reg[0]};
      end
      default: ;  // unknown opcodes retire as no-ops
    endcase
    if (op.addr.cls inside {CLS_SE_IMM, CLS_SNE_IMM, CLS_SE_REG, CLS_SNE_REG}) begin
      target = skip_pc;
    end
  end

  // the VF write lands one cycle after the result, so VF wins when x is F
  assign rf_we   = flag_pend | (pop & wr_en);
  assign rf_idx  = flag_pend ? FLAG_REG : op.regs.x;
  assign rf_data = flag_pend ? {{(DATA_W - 1){1'b0}}, flag_val} : wr_val;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect  <= 1'b0;
      retire    <= 1'b0;
      wb_valid  <= 1'b0;
      flag_pend <= 1'b0;
      sp        <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        v_reg[i] <= '0;
      end
    end else begin
      redirect  <= pop & jump;
      retire    <= pop;
      wb_valid  <= rf_we;
      flag_pend <= pop & flag_en;
      if (rf_we) begin
        v_reg[rf_idx] <= rf_data;
      end
      if (pop && push_ret) begin
        sp <= sp + 1'b1;
      end else if (pop && pop_ret) begin
        sp <= sp_top;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      retire_pc   <= in.pc;
      redirect_pc <= target;
      flag_val    <= alu_flag;
    end
    if (pop && push_ret) begin
      stack_mem[sp] <= seq_pc;  // return address
    end
    if (rf_we) begin
      wb_index <= rf_idx;
      wb_data  <= rf_data;
    end
  end

endmodule

// ==== logic/opcode_queue.sv ====
/* Circular FIFO of fetched opcodes and their addresses between fetch and execute;
   a redirect empties it */
`timescale 1ns/1ps

module opcode_queue
  import chip8_isa_pkg::*, chip8_mem_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            redirect,
  opcode_stream_if.sink   in,
  opcode_stream_if.source out
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(QUEUE_DEPTH - 1);

  opcode_t           op_mem [QUEUE_DEPTH];
  logic [ADDR_W-1:0] pc_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;

  assign in.take    = count != CNT_W'(QUEUE_DEPTH);  // not full
  assign out.valid  = count != '0;
  assign out.opcode = op_mem[rd_ptr];
  assign out.pc     = pc_mem[rd_ptr];

  assign push = in.valid & in.take & ~redirect;
  assign pop  = out.valid & out.take & ~redirect;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (redirect) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr] <= in.opcode;
      pc_mem[wr_ptr] <= in.pc;
    end
  end

endmodule

// ==== logic/opcode_fetch.sv ====
/* Fetch stage: reads the high then the low opcode byte from memory and hands the
   assembled opcode with its pc to the queue; reloads on redirect */
`timescale 1ns/1ps

module opcode_fetch
  import chip8_isa_pkg::*, chip8_mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  output logic              mem_read,
  output logic [ADDR_W-1:0] mem_addr,
  input  logic [DATA_W-1:0] mem_data,
  input  logic              redirect,
  input  logic [ADDR_W-1:0] redirect_pc,
  opcode_stream_if.source   out
);

  logic [ADDR_W-1:0] fetch_ptr;  // pc of the opcode being assembled
  logic              rd_lo;      // current read is the low byte
  logic              data_vld;
  logic              data_lo;
  logic [DATA_W-1:0] hi_byte;
  logic              slot_busy;
  logic              idle;
  logic              cap_hi;
  logic              cap_lo;

  assign slot_busy = out.valid & ~out.take;
  assign cap_hi    = data_vld & ~data_lo & ~redirect;
  assign cap_lo    = data_vld & data_lo & ~redirect;

  // next opcode only starts once nothing is in flight and the output slot drains
  assign idle = ~mem_read & ~data_vld & ~slot_busy;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mem_read  <= 1'b0;
      mem_addr  <= START_PC;
      fetch_ptr <= START_PC;
      rd_lo     <= 1'b0;
      data_vld  <= 1'b0;
      data_lo   <= 1'b0;
      out.valid <= 1'b0;
    end else begin
      data_vld <= mem_read & ~redirect;  // squash the byte still in memory
      data_lo  <= rd_lo;
      mem_read <= 1'b0;
      if (redirect) begin
        mem_read  <= 1'b1;
        mem_addr  <= redirect_pc;
        rd_lo     <= 1'b0;
        fetch_ptr <= redirect_pc;
        out.valid <= 1'b0;
      end else begin
        if (cap_lo) begin
          out.valid <= 1'b1;
          fetch_ptr <= fetch_ptr + INSTR_BYTES;
        end else if (out.take) begin
          out.valid <= 1'b0;
        end
        if (mem_read && !rd_lo) begin
          mem_read <= 1'b1;  // low byte right behind the high byte
          mem_addr <= mem_addr + 1'b1;
          rd_lo    <= 1'b1;
        end else if (idle) begin
          mem_read <= 1'b1;
          mem_addr <= fetch_ptr;
          rd_lo    <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cap_hi) begin
      hi_byte <= mem_data;
    end
    if (cap_lo) begin
      out.opcode <= opcode_t'({hi_byte, mem_data});  // big-endian, high byte at pc
      out.pc     <= fetch_ptr;
    end
  end

endmodule

// ==== logic/opcode_stream_if.sv ====
/* Opcode link between pipeline stages; an item moves on an edge where valid and
   take are both high */
`timescale 1ns/1ps

interface opcode_stream_if
  import chip8_isa_pkg::*, chip8_mem_pkg::*;
();

  logic              valid;
  opcode_t           opcode;
  logic [ADDR_W-1:0] pc;      // address of the opcode's high byte
  logic              take;

  modport source (
    output valid,
    output opcode,
    output pc,
    input  take
  );

  modport sink (
    input  valid,
    input  opcode,
    input  pc,
    output take
  );

endinterface

// ==== logic/chip8_mem_pkg.sv ====
/* Memory and machine widths of the CHIP-8 core */
package chip8_mem_pkg;

  localparam int ADDR_W = 12;  // byte address into the 4 KB space
  localparam int DATA_W = 8;

  localparam int NUM_REGS  = 16;
  localparam int REG_IDX_W = 4;

endpackage

// ==== logic/chip8_isa_pkg.sv ====
/* CHIP-8 instruction set definitions shared by the fetch, queue and execute stages:
   the opcode word with its two decodes, class and ALU codes, and pc constants */
package chip8_isa_pkg;

  // nnn form used by jumps and calls
  typedef struct packed {
    logic [3:0]  cls;
    logic [11:0] target;
  } addr_view_t;

  // xy form; the low byte {y, fn} is the kk immediate
  typedef struct packed {
    logic [3:0] cls;
    logic [3:0] x;
    logic [3:0] y;
    logic [3:0] fn;
  } reg_view_t;

  typedef union packed {
    addr_view_t addr;
    reg_view_t  regs;
  } opcode_t;

  localparam logic [3:0] CLS_SYS     = 4'h0;  // 00E0 and 00EE
  localparam logic [3:0] CLS_JP      = 4'h1;
  localparam logic [3:0] CLS_CALL    = 4'h2;
  localparam logic [3:0] CLS_SE_IMM  = 4'h3;
  localparam logic [3:0] CLS_SNE_IMM = 4'h4;
  localparam logic [3:0] CLS_SE_REG  = 4'h5;
  localparam logic [3:0] CLS_LD_IMM  = 4'h6;
  localparam logic [3:0] CLS_ADD_IMM = 4'h7;
  localparam logic [3:0] CLS_ALU     = 4'h8;
  localparam logic [3:0] CLS_SNE_REG = 4'h9;
  localparam logic [3:0] CLS_JP_V0   = 4'hB;

  // function nibble of the 8xy group
  localparam logic [3:0] ALU_MOV  = 4'h0;
  localparam logic [3:0] ALU_OR   = 4'h1;
  localparam logic [3:0] ALU_AND  = 4'h2;
  localparam logic [3:0] ALU_XOR  = 4'h3;
  localparam logic [3:0] ALU_ADD  = 4'h4;
  localparam logic [3:0] ALU_SUB  = 4'h5;
  localparam logic [3:0] ALU_SHR  = 4'h6;
  localparam logic [3:0] ALU_SUBN = 4'h7;
  localparam logic [3:0] ALU_SHL  = 4'hE;

  localparam logic [11:0] START_PC    = 12'h200;
  localparam logic [11:0] INSTR_BYTES = 12'd2;
  localparam logic [15:0] RET_OPCODE  = 16'h00EE;
  localparam logic [3:0]  FLAG_REG    = 4'd15;  // VF

endpackage
